// ==== src/tm_sch_pkg.sv ====
// Scheduler data types for the priority-scheduler control memory entries.
`default_nettype none

package tm_sch_pkg;

        // Third-level queue ID width.
        localparam int QID_NBITS = 8;

        localparam int ENTRY_NBITS = 2 * QID_NBITS;  // One hi/lo queue pair.

        // Entry as the scheduler decodes it.
        typedef struct packed {
                logic [QID_NBITS-1:0] hi_qid;  // High-priority queue.
                logic [QID_NBITS-1:0] lo_qid;  // Low-priority queue.
        } pri_entry_s;

        // One stored word.
        // Software writes and reads the raw view, the scheduler uses the pair view.
        typedef union packed {
                logic [ENTRY_NBITS-1:0] raw;
                pri_entry_s             pair;
        } pri_entry_u;

        // Scheduler read response, one cycle after app_rd.
        typedef struct packed {
                logic       ack;
                pri_entry_u entry;
        } app_rsp_t;

endpackage

`default_nettype wire

// ==== src/tm_pio_pkg.sv ====
// Register bus types for the AXI4-Lite access path into the scheduler banks.
`default_nettype none

package tm_pio_pkg;

        import tm_sch_pkg::*;

        // Register data and address width.
        localparam int PIO_NBITS = 32;

        // AXI response codes in use.
        typedef enum logic [1:0] {
                RESP_OKAY   = 2'b00,
                RESP_SLVERR = 2'b10
        } axi_resp_e;

        // Software request broadcast to every bank.
        // The flags come first and the entry fills the low bits.
        typedef struct packed {
                logic       wr;
                logic       rd;
                pri_entry_u wdata;
        } pio_req_t;

        // Bank answer to a software read.
        typedef struct packed {
                logic       ack;    // One cycle pulse.
                pri_entry_u rdata;  // Zero unless ack.
        } pio_rsp_t;

endpackage

`default_nettype wire

// ==== src/pri_sch_axil_slave.sv ====
// AXI4-Lite slave that decodes bank and entry, issues bank requests and answers B.
`default_nettype none

module pri_sch_axil_slave #(
        parameter int N_BANKS     = 8,
        parameter int DEPTH_NBITS = 6
) (
        input  logic                                 clk,
        input  logic                                 reset,
        input  logic [tm_pio_pkg::PIO_NBITS-1:0]     s_awaddr,
        input  logic                                 s_awvalid,
        output logic                                 s_awready,
        input  logic [tm_pio_pkg::PIO_NBITS-1:0]     s_wdata,
        input  logic [tm_pio_pkg::PIO_NBITS/8-1:0]   s_wstrb,  // Full-word writes only.
        input  logic                                 s_wvalid,
        output logic                                 s_wready,
        output tm_pio_pkg::axi_resp_e                s_bresp,
        output logic                                 s_bvalid,
        input  logic                                 s_bready,
        input  logic [tm_pio_pkg::PIO_NBITS-1:0]     s_araddr,
        input  logic                                 s_arvalid,
        output logic                                 s_arready,
        output tm_pio_pkg::pio_req_t                 pio_req,
        output logic [N_BANKS-1:0]                   bank_sel,
        output logic [DEPTH_NBITS-1:0]               pio_addr,
        input  logic                                 rd_done,
        output logic                                 rd_err
);
        import tm_pio_pkg::*;

        localparam int BANK_NBITS = $clog2(N_BANKS);
        localparam int TOP_LSB    = DEPTH_NBITS + 2 + BANK_NBITS;  // First out-of-range bit.
        localparam int ENTRY_W    = $bits(pio_req_t) - 2;          // Entry below wr and rd.

        logic                  wr_go;
        logic                  rd_go;
        logic                  aw_hs;
        logic                  ar_hs;
        logic                  aw_oor;
        logic                  ar_oor;
        logic [BANK_NBITS-1:0] aw_bank;
        logic [BANK_NBITS-1:0] ar_bank;
        logic [N_BANKS-1:0]    sel_next;
        logic                  rd_busy;   // One read in flight.
        logic                  rd_err_q;

        // Writes win over reads so the two readies are never high together.
        assign wr_go = s_awvalid & s_wvalid & ~s_awready & ~s_bvalid;
        assign rd_go = s_arvalid & ~s_arready & ~rd_busy & ~wr_go;

        assign aw_hs = s_awready & s_awvalid & s_wvalid;
        assign ar_hs = s_arready & s_arvalid;

        assign aw_oor  = |s_awaddr[PIO_NBITS-1:TOP_LSB];
        assign ar_oor  = |s_araddr[PIO_NBITS-1:TOP_LSB];
        assign aw_bank = s_awaddr[DEPTH_NBITS+2 +: BANK_NBITS];
        assign ar_bank = s_araddr[DEPTH_NBITS+2 +: BANK_NBITS];

        // Out-of-range accesses select no bank.
        always_comb begin
                sel_next = '0;
                if (aw_hs && !aw_oor) begin
                        sel_next[aw_bank] = 1'b1;
                end else if (ar_hs && !ar_oor) begin
                        sel_next[ar_bank] = 1'b1;
                end
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        s_awready <= 1'b0;
                        s_wready  <= 1'b0;
                        s_arready <= 1'b0;
                        s_bvalid  <= 1'b0;
                        rd_busy   <= 1'b0;
                        rd_err_q  <= 1'b0;
                        rd_err    <= 1'b0;
                        bank_sel  <= '0;
                end else begin
                        s_awready <= wr_go;
                        s_wready  <= wr_go;
                        s_arready <= rd_go;
                        bank_sel  <= sel_next;
                        rd_err_q  <= ar_hs & ar_oor;
                        rd_err    <= rd_err_q;  // Lines up with a bank ack.
                        if (aw_hs) begin
                                s_bvalid <= 1'b1;
                        end else if (s_bready) begin
                                s_bvalid <= 1'b0;
                        end
                        if (ar_hs) begin
                                rd_busy <= 1'b1;
                        end else if (rd_done) begin
                                rd_busy <= 1'b0;
                        end
                end
        end

        // Bank request, one cycle after the handshake.
        always_ff @(posedge clk) begin
                if (reset) begin
                        pio_req.wr <= 1'b0;
                        pio_req.rd <= 1'b0;
                end else begin
                        pio_req.wr <= aw_hs & ~aw_oor;
                        pio_req.rd <= ar_hs & ~ar_oor;
                end
                if (aw_hs) begin
                        pio_req.wdata.raw <= s_wdata[ENTRY_W-1:0];
                end
        end

        always_ff @(posedge clk) begin
                if (aw_hs) begin
                        pio_addr <= s_awaddr[DEPTH_NBITS+1:2];
                        s_bresp  <= aw_oor ? RESP_SLVERR : RESP_OKAY;
                end else if (ar_hs) begin
                        pio_addr <= s_araddr[DEPTH_NBITS+1:2];
                end
        end

        a_sel_onehot: assert property (@(posedge clk) disable iff (reset)
                (pio_req.wr || pio_req.rd) |-> $onehot(bank_sel))
                else $error("Bank select is not one-hot during a request.");

endmodule

`default_nettype wire

// ==== src/pri_sch_bank.sv ====
// Priority-scheduler memory bank with a software port and a scheduler read port.
`default_nettype none

module pri_sch_bank #(
        parameter int DEPTH_NBITS = 6
) (
        input  logic                     clk,
        input  logic                     reset,
        input  logic                     sel,
        input  tm_pio_pkg::pio_req_t     pio_req,
        input  logic [DEPTH_NBITS-1:0]   pio_addr,
        output tm_pio_pkg::pio_rsp_t     pio_rsp,
        input  logic                     app_rd,
        input  logic [DEPTH_NBITS-1:0]   app_raddr,
        output tm_sch_pkg::app_rsp_t     app_rsp
);
        import tm_sch_pkg::*;
        import tm_pio_pkg::*;

        localparam int DEPTH = 2 ** DEPTH_NBITS;

        pri_entry_u mem [DEPTH];  // Not reset.
        pio_rsp_t   sw_q;
        logic       sw_wr;
        logic       sw_rd;

        assign sw_wr = sel & pio_req.wr;
        assign sw_rd = sel & pio_req.rd;

        // Single write port, software only.
        always_ff @(posedge clk) begin
                if (sw_wr) begin
                        mem[pio_addr] <= pio_req.wdata;
                end
        end

        // Software read port.
        always_ff @(posedge clk) begin
                if (reset) begin
                        sw_q.ack <= 1'b0;
                end else begin
                        sw_q.ack <= sw_rd;
                end
                if (sw_rd) begin
                        sw_q.rdata <= mem[pio_addr];
                end
        end

        // Zero data keeps the OR merge clean.
        always_comb begin
                pio_rsp.ack   = sw_q.ack;
                pio_rsp.rdata = sw_q.ack ? sw_q.rdata : '0;
        end

        // Scheduler read port.
        // A same-cycle write to the entry is not seen, the old word is returned.
        always_ff @(posedge clk) begin
                if (reset) begin
                        app_rsp.ack <= 1'b0;
                end else begin
                        app_rsp.ack <= app_rd;
                end
                if (app_rd) begin
                        app_rsp.entry <= mem[app_raddr];
                end
        end

        a_no_wr_rd: assert property (@(posedge clk) disable iff (reset)
                !(pio_req.wr && pio_req.rd))
                else $error("Software write and read issued in the same cycle.");

endmodule

`default_nettype wire

// ==== src/pri_sch_rdata_merge.sv ====
// Merges bank read answers into a registered AXI4-Lite R channel.
`default_nettype none

module pri_sch_rdata_merge #(
        parameter int N_BANKS = 8
) (
        input  logic                                  clk,
        input  logic                                  reset,
        input  tm_pio_pkg::pio_rsp_t [N_BANKS-1:0]    bank_rsp,
        input  logic                                  rd_err,
        output logic                                  rd_done,
        output logic [tm_pio_pkg::PIO_NBITS-1:0]      s_rdata,
        output tm_pio_pkg::axi_resp_e                 s_rresp,
        output logic                                  s_rvalid,
        input  logic                                  s_rready
);
        import tm_pio_pkg::*;

        pio_rsp_t           rsp_or;
        logic [N_BANKS-1:0] ack_vec;
        logic               rd_load;

        // Banks without ack drive zero.
        always_comb begin
                rsp_or = '0;
                for (int i = 0; i < N_BANKS; i++) begin
                        rsp_or     = rsp_or | bank_rsp[i];
                        ack_vec[i] = bank_rsp[i].ack;
                end
        end

        assign rd_load = rsp_or.ack | rd_err;
        assign rd_done = s_rvalid & s_rready;

        always_ff @(posedge clk) begin
                if (reset) begin
                        s_rvalid <= 1'b0;
                end else if (rd_load) begin
                        s_rvalid <= 1'b1;
                end else if (s_rready) begin
                        s_rvalid <= 1'b0;
                end
        end

        always_ff @(posedge clk) begin
                if (rd_load) begin
                        s_rdata <= PIO_NBITS'(rsp_or.rdata.raw);  // Zero-extended.
                        s_rresp <= rd_err ? RESP_SLVERR : RESP_OKAY;
                end
        end

        a_one_ack: assert property (@(posedge clk) disable iff (reset) $onehot0(ack_vec))
                else $error("More than one bank answered a software read.");

endmodule

`default_nettype wire

// ==== src/tm_sch_pri_mem.sv ====
// Priority-scheduler control memory with AXI4-Lite access and per-bank scheduler reads.
`default_nettype none

module tm_sch_pri_mem #(
        parameter int N_BANKS     = 8,   // Power of two.
        parameter int DEPTH_NBITS = 6
) (
        input  logic                                     clk,
        input  logic                                     reset,
        input  logic [tm_pio_pkg::PIO_NBITS-1:0]         s_awaddr,
        input  logic                                     s_awvalid,
        output logic                                     s_awready,
        input  logic [tm_pio_pkg::PIO_NBITS-1:0]         s_wdata,
        input  logic [tm_pio_pkg::PIO_NBITS/8-1:0]       s_wstrb,
        input  logic                                     s_wvalid,
        output logic                                     s_wready,
        output tm_pio_pkg::axi_resp_e                    s_bresp,
        output logic                                     s_bvalid,
        input  logic                                     s_bready,
        input  logic [tm_pio_pkg::PIO_NBITS-1:0]         s_araddr,
        input  logic                                     s_arvalid,
        output logic                                     s_arready,
        output logic [tm_pio_pkg::PIO_NBITS-1:0]         s_rdata,
        output tm_pio_pkg::axi_resp_e                    s_rresp,
        output logic                                     s_rvalid,
        input  logic                                     s_rready,
        input  logic [N_BANKS-1:0]                       app_rd,
        input  logic [N_BANKS-1:0][DEPTH_NBITS-1:0]      app_raddr,
        output tm_sch_pkg::app_rsp_t [N_BANKS-1:0]       app_rsp
);
        import tm_pio_pkg::*;

        pio_req_t                 pio_req;
        logic [N_BANKS-1:0]       bank_sel;
        logic [DEPTH_NBITS-1:0]   pio_addr;
        pio_rsp_t [N_BANKS-1:0]   bank_rsp;
        logic                     rd_done;
        logic                     rd_err;

        pri_sch_axil_slave #(
                .N_BANKS     (N_BANKS),
                .DEPTH_NBITS (DEPTH_NBITS)
        ) u_slave (
                .clk       (clk),
                .reset     (reset),
                .s_awaddr  (s_awaddr),
                .s_awvalid (s_awvalid),
                .s_awready (s_awready),
                .s_wdata   (s_wdata),
                .s_wstrb   (s_wstrb),
                .s_wvalid  (s_wvalid),
                .s_wready  (s_wready),
                .s_bresp   (s_bresp),
                .s_bvalid  (s_bvalid),
                .s_bready  (s_bready),
                .s_araddr  (s_araddr),
                .s_arvalid (s_arvalid),
                .s_arready (s_arready),
                .pio_req   (pio_req),
                .bank_sel  (bank_sel),
                .pio_addr  (pio_addr),
                .rd_done   (rd_done),
                .rd_err    (rd_err)
        );

        // Request and index are shared, bank_sel picks the bank.
        for (genvar i = 0; i < N_BANKS; i++) begin : u_bank
                pri_sch_bank #(
                        .DEPTH_NBITS (DEPTH_NBITS)
                ) u_bank_mem (
                        .clk       (clk),
                        .reset     (reset),
                        .sel       (bank_sel[i]),
                        .pio_req   (pio_req),
                        .pio_addr  (pio_addr),
                        .pio_rsp   (bank_rsp[i]),
                        .app_rd    (app_rd[i]),
                        .app_raddr (app_raddr[i]),
                        .app_rsp   (app_rsp[i])
                );
        end

        pri_sch_rdata_merge #(
                .N_BANKS (N_BANKS)
        ) u_merge (
                .clk      (clk),
                .reset    (reset),
                .bank_rsp (bank_rsp),
                .rd_err   (rd_err),
                .rd_done  (rd_done),
                .s_rdata  (s_rdata),
                .s_rresp  (s_rresp),
                .s_rvalid (s_rvalid),
                .s_rready (s_rready)
        );

endmodule

`default_nettype wire

// ==== verification/tb_tm_sch_pri_mem.sv ====
// Testbench for the priority-scheduler control memory, driven by a golden data file.
`default_nettype none

module tb_tm_sch_pri_mem;
        import tm_sch_pkg::*;
        import tm_pio_pkg::*;

        localparam int N_BANKS     = 8;
        localparam int DEPTH_NBITS = 6;
        localparam int BANK_NBITS  = $clog2(N_BANKS);
        localparam int TIMEOUT     = 32;  // Cycles allowed per wait.
        localparam int RD_LATENCY  = 3;   // Cycles from ar handshake to rvalid.

        typedef logic [8*24-1:0] name_t;

        logic                                clk;
        logic                                reset;
        logic [PIO_NBITS-1:0]                s_awaddr;
        logic                                s_awvalid;
        logic                                s_awready;
        logic [PIO_NBITS-1:0]                s_wdata;
        logic [PIO_NBITS/8-1:0]              s_wstrb;
        logic                                s_wvalid;
        logic                                s_wready;
        axi_resp_e                           s_bresp;
        logic                                s_bvalid;
        logic                                s_bready;
        logic [PIO_NBITS-1:0]                s_araddr;
        logic                                s_arvalid;
        logic                                s_arready;
        logic [PIO_NBITS-1:0]                s_rdata;
        axi_resp_e                           s_rresp;
        logic                                s_rvalid;
        logic                                s_rready;
        logic [N_BANKS-1:0]                  app_rd;
        logic [N_BANKS-1:0][DEPTH_NBITS-1:0] app_raddr;
        app_rsp_t [N_BANKS-1:0]              app_rsp;

        logic [31:0]    lfsr;
        int             fd;
        int             rc;
        int             ops;
        name_t          op;
        name_t          name;
        logic [31:0]    addr;
        logic [31:0]    data;
        logic [31:0]    expv;
        logic [8*128-1:0] line;
        pri_entry_u     exp_entry;

        tm_sch_pri_mem u_dut (.*);

        initial begin
                clk = 1'b0;
                forever begin
                        #2 clk = ~clk;
                end
        end

        function automatic logic [31:0] lfsr_step(input logic [31:0] s);
                return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
        endfunction

        // Two LFSR bits give an idle delay of 0 to 3 cycles.
        task automatic draw_delay(output int d);
                d = 0;
                for (int i = 0; i < 2; i++) begin
                        lfsr = lfsr_step(lfsr);
                        d    = (d << 1) | int'(lfsr[0]);
                end
        endtask

        task automatic abort_run();
                $display("Regression failed");
                $fatal(1, "Stopped at the first error.");
        endtask

        task automatic timeout_fail(input string what);
                $display("Timed out waiting for %s.", what);
                abort_run();
        endtask

        task automatic check_resp(input name_t tname, input axi_resp_e exp, input axi_resp_e act);
                if (act !== exp) begin
                        $display("Fail %0s expected resp %h actual resp %h", tname, exp, act);
                        abort_run();
                end
        endtask

        task automatic check_rdata(input name_t tname, input logic [PIO_NBITS-1:0] exp,
                                   input logic [PIO_NBITS-1:0] act);
                if (act !== exp) begin
                        $display("Fail %0s expected rdata %h actual rdata %h", tname, exp, act);
                        abort_run();
                end
        endtask

        task automatic check_entry(input name_t tname, input pri_entry_u exp,
                                   input pri_entry_u act);
                if (act.pair.hi_qid !== exp.pair.hi_qid ||
                    act.pair.lo_qid !== exp.pair.lo_qid) begin
                        $display("Fail %0s expected hi %h lo %h actual hi %h lo %h", tname,
                                 exp.pair.hi_qid, exp.pair.lo_qid, act.pair.hi_qid, act.pair.lo_qid);
                        abort_run();
                end
        endtask

        task automatic check_latency(input name_t tname, input int exp, input int act);
                if (act != exp) begin
                        $display("Fail %0s expected latency %0d actual latency %0d",
                                 tname, exp, act);
                        abort_run();
                end
        endtask

        task automatic axi_write(input name_t tname, input logic [31:0] a, input logic [31:0] d,
                                 input axi_resp_e exp);
                int        n;
                int        delay;
                axi_resp_e first;
                s_awaddr  = a;
                s_wdata   = d;
                s_awvalid = 1'b1;
                s_wvalid  = 1'b1;
                n         = 0;
                while (!(s_awready && s_wready)) begin
                        @(negedge clk);
                        n++;
                        if (n > TIMEOUT) begin
                                timeout_fail("the write address and data handshake");
                        end
                end
                @(negedge clk);  // Handshake taken on the edge before.
                s_awvalid = 1'b0;
                s_wvalid  = 1'b0;
                if (!s_bvalid) begin
                        $display("Write %0s got no bvalid after its handshake.", tname);
                        abort_run();
                end
                first = s_bresp;
                draw_delay(delay);
                repeat (delay) begin
                        @(negedge clk);
                        if (!s_bvalid) begin
                                $display("Write %0s dropped bvalid before bready.", tname);
                                abort_run();
                        end
                        check_resp(tname, first, s_bresp);
                end
                s_bready = 1'b1;
                check_resp(tname, exp, s_bresp);
                @(negedge clk);
                s_bready = 1'b0;
        endtask

        task automatic axi_read(input name_t tname, input logic [31:0] a,
                                input logic [PIO_NBITS-1:0] exp_data, input axi_resp_e exp);
                int                   n;
                int                   lat;
                int                   delay;
                logic [PIO_NBITS-1:0] first_data;
                axi_resp_e            first_resp;
                s_araddr  = a;
                s_arvalid = 1'b1;
                n         = 0;
                while (!s_arready) begin
                        @(negedge clk);
                        n++;
                        if (n > TIMEOUT) begin
                                timeout_fail("the read address handshake");
                        end
                end
                lat = 0;
                while (!s_rvalid) begin
                        @(negedge clk);
                        lat++;
                        if (lat == 1) begin
                                s_arvalid = 1'b0;
                        end
                        if (lat > TIMEOUT) begin
                                timeout_fail("read data valid");
                        end
                end
                check_latency(tname, RD_LATENCY, lat);
                first_data = s_rdata;
                first_resp = s_rresp;
                draw_delay(delay);
                repeat (delay) begin
                        @(negedge clk);
                        if (!s_rvalid) begin
                                $display("Read %0s dropped rvalid before rready.", tname);
                                abort_run();
                        end
                        check_rdata(tname, first_data, s_rdata);
                        check_resp(tname, first_resp, s_rresp);
                end
                s_rready = 1'b1;
                check_rdata(tname, exp_data, s_rdata);
                check_resp(tname, exp, s_rresp);
                @(negedge clk);
                s_rready = 1'b0;
        endtask

        // Bank and index come from the address fields, one read per cycle.
        task automatic app_read(input name_t tname, input logic [31:0] a, input pri_entry_u exp);
                int b;
                b            = int'(a[DEPTH_NBITS+2 +: BANK_NBITS]);
                app_rd       = '0;
                app_rd[b]    = 1'b1;
                app_raddr[b] = a[DEPTH_NBITS+1:2];
                @(negedge clk);
                app_rd = '0;
                if (app_rsp[b].ack !== 1'b1) begin
                        $display("Scheduler read %0s got no ack one cycle after app_rd.", tname);
                        abort_run();
                end
                check_entry(tname, exp, app_rsp[b].entry);
        endtask

        initial begin
                reset     = 1'b1;
                s_awaddr  = '0;
                s_awvalid = 1'b0;
                s_wdata   = '0;
                s_wstrb   = '1;  // Ignored by the DUT.
                s_wvalid  = 1'b0;
                s_bready  = 1'b0;
                s_araddr  = '0;
                s_arvalid = 1'b0;
                s_rready  = 1'b0;
                app_rd    = '1;  // Scheduler reads held during reset.
                app_raddr = '0;
                lfsr      = 32'h64b4_91d5;
                ops       = 0;
                repeat (5) @(posedge clk);
                @(negedge clk);
                reset  = 1'b0;
                app_rd = '0;
                for (int i = 0; i < N_BANKS; i++) begin
                        if (app_rsp[i].ack !== 1'b0) begin
                                $display("Scheduler ack of bank %0d is not low after reset.", i);
                                abort_run();
                        end
                end
                if (s_bvalid !== 1'b0 || s_rvalid !== 1'b0) begin
                        $display("bvalid or rvalid is not low after reset.");
                        abort_run();
                end
                fd = $fopen("verification/pri_mem_golden.txt", "r");
                if (fd == 0) begin
                        $display("Cannot open the golden data file.");
                        abort_run();
                end
                while ($fscanf(fd, "%s", op) == 1) begin
                        if (op == "#") begin
                                rc = $fgets(line, fd);  // Skip the comment text.
                        end else begin
                                rc = $fscanf(fd, "%s %h %h %h", name, addr, data, expv);
                                if (rc != 4) begin
                                        $display("Malformed line in the golden data file.");
                                        abort_run();
                                end
                                exp_entry.raw = expv[ENTRY_NBITS-1:0];
                                case (op)
                                        "W": axi_write(name, addr, data, axi_resp_e'(expv[1:0]));
                                        "R": axi_read(name, addr, data, axi_resp_e'(expv[1:0]));
                                        "A": app_read(name, addr, exp_entry);
                                        default: begin
                                                $display("Unknown operation in the data file.");
                                                abort_run();
                                        end
                                endcase
                                ops++;
                        end
                end
                $fclose(fd);
                if (ops == 0) begin
                        $display("No operations were read from the golden data file.");
                        abort_run();
                end else begin
                        $display("Regression passed");
                        $finish;
                end
        end

endmodule

`default_nettype wire

// ==== build.f ====
src/tm_sch_pkg.sv
src/tm_pio_pkg.sv
src/pri_sch_axil_slave.sv
src/pri_sch_bank.sv
src/pri_sch_rdata_merge.sv
src/tm_sch_pri_mem.sv
verification/tb_tm_sch_pri_mem.sv

// ==== Bender.yml ====
package:
  name: tm_sch_pri_mem

sources:
  # Packages first, the register bus types import the scheduler types.
  - src/tm_sch_pkg.sv
  - src/tm_pio_pkg.sv
  - src/pri_sch_axil_slave.sv
  - src/pri_sch_bank.sv
  - src/pri_sch_rdata_merge.sv
  - src/tm_sch_pri_mem.sv
  - target: test
    files:
      - verification/tb_tm_sch_pri_mem.sv

// ==== verification/pri_mem_golden.txt ====
# op name addr data expected; W data is the written word and expected the resp code
# R data is the expected read word; A addr gives bank and index, expected is the entry
W wr_bank0 00000014 ffff1100 0
W wr_bank1 00000114 00002211 0
W wr_bank2 00000214 12343322 0
W wr_bank3 00000314 00004433 0
W wr_bank4 00000414 00005544 0
W wr_bank5 00000514 0000abcd 0
W wr_bank6 00000614 00007766 0
W wr_bank7 00000714 dead8877 0
R rd_bank0 00000014 00001100 0
R rd_bank1 00000114 00002211 0
R rd_bank2 00000214 00003322 0
R rd_bank3 00000317 00004433 0
R rd_bank4 00000414 00005544 0
R rd_bank5 00000514 0000abcd 0
R rd_bank6 00000614 00007766 0
R rd_bank7 00000714 00008877 0
A app_bank0 00000014 0 1100
A app_bank1 00000114 0 2211
A app_bank5 00000514 0 abcd
A app_bank7 00000714 0 8877
W iso_wr_b2 000002fc 0000c0de 0
W iso_wr_b6 000006fc 0000beef 0
R iso_rd_b2 000002fc 0000c0de 0
R iso_rd_b6 000006fc 0000beef 0
A iso_app_b2 000002fc 0 c0de
A iso_app_b6 000006fc 0 beef
W oor_wr 00000814 0000ffff 2
R oor_rd 00010014 00000000 2
R oor_chk_b0 00000014 00001100 0
A oor_app_b0 00000014 0 1100
